// File: all.f
verilog/timer_pkg.sv
verilog/timer.sv
verilog/event_fifo.sv
verilog/capture_reader.sv
verilog/timer_capture_top.sv
bench/timer_capture_assert.sv
bench/timer_capture_tb.sv

// File: bench/timer_capture_assert.sv
`timescale 1ns/1ps
`default_nettype none

module timer_capture_assert #(
    parameter int unsigned DEPTH = 4
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       write_i,
    input  logic       read_i,
    input  logic       write_error_i,
    input  logic       read_error_i,
    input  logic       interrupt_i,
    input  logic       capture_irq_i,
    input  logic [7:0] fifo_count_i
);

    // match edge is one cycle wide, so the irq pulse is too
    irq_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        interrupt_i |=> !interrupt_i)
        else $error("interrupt_o high for two cycles in a row");

    // level irq against the fill count, not the empty flag it is built from
    capture_irq_level: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        capture_irq_i == (fifo_count_i != 8'd0))
        else $error("capture_irq_o does not follow the FIFO fill state");

    count_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fifo_count_i <= 8'(DEPTH))
        else $error("FIFO count above its depth");

    write_error_strobed: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        write_error_i |-> write_i)
        else $error("write_error_o without a write strobe");

    read_error_strobed: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        read_error_i |-> read_i)
        else $error("read_error_o without a read strobe");

endmodule : timer_capture_assert

bind timer_capture_top timer_capture_assert #(
    .DEPTH (FIFO_DEPTH)
) u_assert (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .write_i       (write_i),
    .read_i        (read_i),
    .write_error_i (write_error_o),
    .read_error_i  (read_error_o),
    .interrupt_i   (interrupt_o),
    .capture_irq_i (capture_irq_o),
    .fifo_count_i  (fifo_count)
);

`default_nettype wire

// File: bench/timer_capture_tb.sv
`timescale 1ns/1ps
`default_nettype none

module timer_capture_tb;

    import timer_pkg::*;

    localparam int unsigned FIFO_DEPTH = 4;
    localparam int          TIMEOUT    = 300;       // cycles allowed per wait

    logic              clk_i;
    logic              rst_n_i;
    logic              write_i;
    logic [ADDR_W-1:0] write_addr_i;
    logic [DATA_W-1:0] write_data_i;
    logic              read_i;
    logic [ADDR_W-1:0] read_addr_i;
    logic [DATA_W-1:0] read_data_o;
    logic              write_error_o;
    logic              read_error_o;
    logic              interrupt_o;
    logic              capture_irq_o;

    int         errors;                             // all tests
    int         test_errors;                        // current test only
    int         checks;
    int         seed;
    int         irq_pulses;                         // interrupt cycles seen
    logic [7:0] next_seq;                           // expected seq of next match

    timer_capture_top #(.FIFO_DEPTH(FIFO_DEPTH)) u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;                  // 8 ns period
    end

    // sampled mid-cycle where the comb irq is settled
    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            irq_pulses <= 0;
        end else if (interrupt_o) begin
            irq_pulses <= irq_pulses + 1;
        end
    end

    function automatic logic [ADDR_W-1:0] timer_addr(input logic [2:0] a);
        return {1'b0, a};
    endfunction

    function automatic logic [ADDR_W-1:0] cap_addr(input logic [2:0] a);
        return {1'b1, a};                           // capture window, 8..15
    endfunction

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] expected);
        checks++;
        if (got !== expected) begin
            $display("Error at %0t: %s got %h expected %h", $time, name, got, expected);
            note_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        checks++;
        if (got !== expected) begin
            $display("Error at %0t: %s got %b expected %b", $time, name, got, expected);
            note_error();
        end
    endtask

    task automatic check_config(input string name, input timer_config_t got,
                                input timer_config_t expected);
        checks++;
        if (got !== expected) begin
            $display("Error at %0t: %s got %b expected %b", $time, name, got, expected);
            note_error();
        end
    endtask

    task automatic check_event(input string name, input capture_event_t got,
                               input capture_event_t expected);
        checks++;
        if (got !== expected) begin
            $display("Error at %0t: %s got seq %h ts %h expected seq %h ts %h", $time, name,
                     got.seq, got.timestamp, expected.seq, expected.timestamp);
            note_error();
        end
    endtask

    task automatic check_status(input string name, input capture_status_t got,
                                input capture_status_t expected);
        checks++;
        if (got !== expected) begin
            $display("Error at %0t: %s got ovf %b count %0d expected ovf %b count %0d",
                     $time, name, got.overflow, got.count, expected.overflow, expected.count);
            note_error();
        end
    endtask

    // called 1 ns after an edge, returns 1 ns after the next one
    task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             output logic err);
        write_i      = 1'b1;
        write_addr_i = addr;
        write_data_i = data;
        #1;
        err = write_error_o;                        // comb flag, settled by now
        @(posedge clk_i);
        #1;
        write_i = 1'b0;
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                            output logic err);
        read_i      = 1'b1;
        read_addr_i = addr;
        #1;
        data = read_data_o;
        err  = read_error_o;
        @(posedge clk_i);                           // head pop lands here
        #1;
        read_i = 1'b0;
    endtask

    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        logic err;
        bus_write(addr, data, err);
        check_bit($sformatf("write_error_o at %0d", addr), err, 1'b0);
    endtask

    task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        logic err;
        bus_read(addr, data, err);
        check_bit($sformatf("read_error_o at %0d", addr), err, 1'b0);
    endtask

    // high byte of the timestamp is not on the bus
    task automatic read_event(output capture_event_t ev);
        logic [DATA_W-1:0] low;
        logic [DATA_W-1:0] high;
        read_reg(cap_addr(ADDR_HEAD_LOW), low);
        read_reg(cap_addr(ADDR_HEAD_HIGH), high);   // pops
        ev.seq       = high[31:24];
        ev.timestamp = {8'd0, high[23:0], low};
    endtask

    // compare high parked at all ones so no partial write can match
    task automatic arm_one_shot(input logic [31:0] base, input logic [31:0] cmp,
                                input timer_config_t cfg);
        write_reg(timer_addr(ADDR_COMPARE_HIGH), 32'hFFFF_FFFF);
        write_reg(timer_addr(ADDR_TIMER_HIGH), 32'd0);
        write_reg(timer_addr(ADDR_TIMER_LOW), base);
        write_reg(timer_addr(ADDR_COMPARE_LOW), cmp);
        write_reg(timer_addr(ADDR_COMPARE_HIGH), 32'd0);
        write_reg(timer_addr(ADDR_CONFIG), {29'd0, cfg});  // bit 3 clear, starts
    endtask

    task automatic wait_for_flag(input bit capture_side, input string name, output bit seen);
        int cycles;
        seen = 1'b0;
        for (cycles = 0; cycles < TIMEOUT && !seen; cycles++) begin
            if (capture_side ? capture_irq_o : interrupt_o) begin
                seen = 1'b1;
            end else begin
                @(posedge clk_i);
                #1;
            end
        end
        if (!seen) begin
            $display("timeout: %s did not rise within %0d cycles", name, TIMEOUT);
            note_error();
        end
    endtask

    task automatic report_test(input string name);
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic test_reset_state();
        logic [DATA_W-1:0] data;
        read_reg(timer_addr(ADDR_COMPARE_LOW), data);
        check_word("compare_low", data, 32'hFFFF_FFFF);
        read_reg(timer_addr(ADDR_COMPARE_HIGH), data);
        check_word("compare_high", data, 32'hFFFF_FFFF);
        read_reg(timer_addr(ADDR_TIMER_LOW), data);
        check_word("timer_low", data, 32'd0);
        read_reg(timer_addr(ADDR_TIMER_HIGH), data);
        check_word("timer_high", data, 32'd0);
        read_reg(timer_addr(ADDR_CONFIG), data);
        check_config("config", timer_config_t'(data[2:0]), '0);
        check_bit("stop", data[3], 1'b1);
        read_reg(cap_addr(ADDR_STATUS), data);
        check_status("status", capture_status_t'(data[8:0]), '0);
        check_bit("interrupt_o", interrupt_o, 1'b0);
        check_bit("capture_irq_o", capture_irq_o, 1'b0);
        report_test("reset state");
    endtask

    task automatic test_registers();
        logic [DATA_W-1:0] vals [4];
        logic [DATA_W-1:0] data;
        logic              err;
        int                a;
        for (a = 0; a < 4; a++) begin               // compare lo/hi, timer lo/hi
            vals[a] = $random(seed);
            write_reg(timer_addr(3'(a)), vals[a]);
        end
        for (a = 0; a < 4; a++) begin
            read_reg(timer_addr(3'(a)), data);
            check_word($sformatf("timer reg %0d", a), data, vals[a]);
        end
        for (a = 5; a < 16; a++) begin
            bus_write(4'(a), $random(seed), err);
            check_bit($sformatf("write_error_o at %0d", a), err, (a < 8) || (a > 10));
            if (a != 8 && a != 9) begin             // empty head reads flag too
                bus_read(4'(a), data, err);
                check_bit($sformatf("read_error_o at %0d", a), err, a != 10);
            end
        end
        report_test("register access");
    endtask

    task automatic test_one_shot(input bit irq_on);
        logic [31:0]       cmp;
        logic [DATA_W-1:0] data;
        timer_config_t     cfg;
        capture_event_t    ev;
        int                pulses;
        bit                seen;
        cmp    = 32'd8 + ($random(seed) & 32'h1f);
        cfg    = '{interrupt_enable: irq_on, one_shot: 1'b1, enable: 1'b1};
        pulses = irq_pulses;
        arm_one_shot(32'd0, cmp, cfg);
        wait_for_flag(!irq_on, irq_on ? "interrupt_o" : "capture_irq_o", seen);
        @(posedge clk_i);                           // one-shot stop takes effect
        #1;
        check_word("interrupt pulses", irq_pulses - pulses, irq_on ? 1 : 0);
        read_reg(timer_addr(ADDR_CONFIG), data);
        check_bit("stop", data[3], 1'b1);
        check_config("config", timer_config_t'(data[2:0]), cfg);
        read_reg(timer_addr(ADDR_TIMER_LOW), data);
        check_word("timer_low", data, cmp + 32'd1);
        check_bit("capture_irq_o", capture_irq_o, 1'b1);
        read_event(ev);
        check_event("head event", ev, '{seq: next_seq, timestamp: {32'd0, cmp}});
        next_seq++;
        check_bit("capture_irq_o after pop", capture_irq_o, 1'b0);
        report_test(irq_on ? "one-shot match" : "interrupt disabled");
    endtask

    task automatic test_fifo_overflow();
        capture_event_t    expected_q [$];
        capture_event_t    ev;
        timer_config_t     cfg;
        logic [31:0]       base;
        logic [31:0]       cmp;
        logic [DATA_W-1:0] data;
        bit                seen;
        int                i;
        cfg = '{interrupt_enable: 1'b1, one_shot: 1'b1, enable: 1'b1};
        for (i = 0; i < 6; i++) begin
            base = $random(seed) & 32'hff;
            cmp  = base + 32'd4 + ($random(seed) & 32'h1f);  // always above base
            arm_one_shot(base, cmp, cfg);
            wait_for_flag(1'b0, "interrupt_o", seen);
            @(posedge clk_i);
            #1;
            expected_q.push_back('{seq: next_seq, timestamp: {32'd0, cmp}});
            next_seq++;
        end
        read_reg(cap_addr(ADDR_STATUS), data);
        check_status("status full", capture_status_t'(data[8:0]),
                     '{overflow: 1'b1, count: 8'(FIFO_DEPTH)});
        for (i = 0; i < FIFO_DEPTH; i++) begin      // last two were dropped
            read_event(ev);
            check_event($sformatf("event %0d", i), ev, expected_q[i]);
        end
        write_reg(cap_addr(ADDR_STATUS), 32'd0);
        read_reg(cap_addr(ADDR_STATUS), data);
        check_status("status cleared", capture_status_t'(data[8:0]), '0);
        check_bit("capture_irq_o", capture_irq_o, 1'b0);
        report_test("fifo order and overflow");
    endtask

    initial begin
        errors       = 0;
        test_errors  = 0;
        checks       = 0;
        seed         = 32'h13c194bc;
        next_seq     = 8'd0;
        rst_n_i      = 1'b0;
        write_i      = 1'b0;
        write_addr_i = '0;
        write_data_i = '0;
        read_i       = 1'b0;
        read_addr_i  = '0;
        repeat (5) @(posedge clk_i);                // sync reset, 5 edges
        #1;
        rst_n_i = 1'b1;

        test_reset_state();
        test_registers();
        test_one_shot(1'b1);
        test_one_shot(1'b0);
        test_fifo_overflow();

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : timer_capture_tb

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the timer capture testbench with Verilator

LOG=sim.log
OBJ=obj_dir

if ! cd "$(dirname "$0")"; then
    echo "cannot enter project root"
    exit 1
fi

if ! verilator --binary --timing --assert -Mdir "$OBJ" -f all.f \
        --top-module timer_capture_tb -o sim_tb; then
    echo "build failed"
    exit 1
fi

if ! "./$OBJ/sim_tb" > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error"
    exit 1
fi
cat "$LOG"

# the log decides the result
if grep -q "All tests passed" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// File: verilog/capture_reader.sv
`timescale 1ns/1ps
`default_nettype none

module capture_reader #(
    parameter int unsigned DEPTH = 4
) (
    input  logic                           clk_i,
    input  logic                           rst_n_i,

    input  logic                           write_i,
    input  logic [2:0]                     write_addr_i,

    input  logic                           read_i,
    input  logic [2:0]                     read_addr_i,
    output logic [timer_pkg::DATA_W-1:0]   read_data_o,

    output logic                           write_error_o,
    output logic                           read_error_o,

    input  timer_pkg::capture_event_t      head_i,
    input  logic                           empty_i,
    input  logic [7:0]                     count_i,
    input  logic                           overflow_i,

    output logic                           pop_o,
    output logic                           capture_irq_o
);

    import timer_pkg::*;

    localparam int unsigned CNT_W = $clog2(DEPTH + 1);  // bits that can be nonzero

    capture_status_t status;
    logic            overflow_q;                    // sticky drop flag
    logic            head_addr;                     // read targets a head word

    assign head_addr = (read_addr_i == ADDR_HEAD_LOW) || (read_addr_i == ADDR_HEAD_HIGH);

    // set beats clear so a drop in the clearing cycle is not lost
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            overflow_q <= 1'b0;
        end else if (overflow_i) begin
            overflow_q <= 1'b1;
        end else if (write_i && (write_addr_i == ADDR_STATUS)) begin
            overflow_q <= 1'b0;                     // any data clears it
        end
    end

    assign status.overflow = overflow_q;
    assign status.count    = 8'(count_i[CNT_W-1:0]);

    always_comb begin
        read_data_o = '0;
        case (read_addr_i)
            ADDR_HEAD_LOW: begin
                if (!empty_i) begin
                    read_data_o = head_i.timestamp[31:0];
                end
            end
            ADDR_HEAD_HIGH: begin
                // seq rides in the top byte, timestamp bits 63:56 not shown
                if (!empty_i) begin
                    read_data_o = {head_i.seq, head_i.timestamp[55:32]};
                end
            end
            ADDR_STATUS: read_data_o = DATA_W'(status);
            default:     read_data_o = '0;
        endcase
    end

    assign pop_o         = read_i && (read_addr_i == ADDR_HEAD_HIGH) && !empty_i;
    assign read_error_o  = read_i && ((read_addr_i > ADDR_STATUS) || (head_addr && empty_i));
    assign write_error_o = write_i && (write_addr_i > ADDR_STATUS);  // head writes ignored
    assign capture_irq_o = !empty_i;                // level while entries wait

endmodule : capture_reader

`default_nettype wire

// File: verilog/event_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module event_fifo #(
    parameter type         payload_t = logic [31:0],
    parameter int unsigned DEPTH     = 4
) (
    input  logic     clk_i,
    input  logic     rst_n_i,

    input  logic     push_i,
    input  payload_t push_data_i,

    input  logic     pop_i,
    output payload_t head_o,

    output logic     empty_o,
    output logic [7:0] count_o,
    output logic     overflow_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t         mem_q [DEPTH];                // storage, no reset needed
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [7:0]       count_q;
    logic             full;
    logic             do_pop;
    logic             do_push;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        nxt = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;  // wrap for any depth
        return nxt;
    endfunction : next_ptr

    assign full    = (count_q == 8'(DEPTH));
    assign do_pop  = pop_i && (count_q != 8'd0);    // ignore pop on empty
    assign do_push = push_i && (!full || do_pop);   // pop frees a slot first

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 8'd1;
                2'b01:   count_q <= count_q - 8'd1;
                default: count_q <= count_q;        // both or neither
            endcase
        end
    end

    assign head_o     = mem_q[rd_ptr_q];            // valid only when not empty
    assign empty_o    = (count_q == 8'd0);
    assign count_o    = count_q;
    assign overflow_o = push_i && full && !do_pop;  // dropped push, one cycle

endmodule : event_fifo

`default_nettype wire

// File: verilog/timer.sv
`timescale 1ns/1ps
`default_nettype none

module timer (
    input  logic                           clk_i,
    input  logic                           rst_n_i,

    input  logic                           write_i,
    input  logic [2:0]                     write_addr_i,
    input  logic [timer_pkg::DATA_W-1:0]   write_data_i,

    input  logic                           read_i,
    input  logic [2:0]                     read_addr_i,
    output logic [timer_pkg::DATA_W-1:0]   read_data_o,

    output logic                           write_error_o,
    output logic                           read_error_o,

    output logic                           interrupt_o,
    output logic                           event_valid_o,
    output timer_pkg::capture_event_t      event_data_o
);

    import timer_pkg::*;

    logic [7:0]             wr_en;                  // one-hot write decode
    logic [1:0][DATA_W-1:0] compare_q;              // {high, low}
    logic [1:0][DATA_W-1:0] counter_q;              // {high, low}
    timer_config_t          config_q;
    timer_config_t          config_wr;              // incoming config word
    logic                   stop_q;                 // bit 3 of config readback
    logic                   equal;                  // counter hits compare
    logic                   equal_q;                // last cycle's compare
    logic                   match_edge;             // rising edge of equal
    logic [7:0]             seq_q;                  // next event number

    assign wr_en     = write_i ? (8'd1 << write_addr_i) : 8'd0;
    assign config_wr = timer_config_t'(write_data_i[2:0]);

    assign write_error_o = write_i && (write_addr_i > ADDR_CONFIG);  // 5..7 unmapped
    assign read_error_o  = read_i && (read_addr_i > ADDR_CONFIG);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            compare_q <= '1;                        // never matches right after reset
        end else begin
            if (wr_en[ADDR_COMPARE_LOW]) begin
                compare_q[0] <= write_data_i;
            end
            if (wr_en[ADDR_COMPARE_HIGH]) begin
                compare_q[1] <= write_data_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            config_q <= '0;
        end else if (wr_en[ADDR_CONFIG]) begin
            config_q <= config_wr;
        end
    end

    // stop bit: one-shot match wins over a config write in the same cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            stop_q <= 1'b1;
        end else if (match_edge && config_q.enable && config_q.one_shot) begin
            stop_q <= 1'b1;                         // halt, counter ends at compare+1
        end else if (wr_en[ADDR_CONFIG]) begin
            stop_q <= !config_wr.enable || write_data_i[3];  // clear bit 3 to restart
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            counter_q <= '0;
        end else if (wr_en[ADDR_TIMER_LOW]) begin
            counter_q[0] <= write_data_i;           // load beats the increment
        end else if (wr_en[ADDR_TIMER_HIGH]) begin
            counter_q[1] <= write_data_i;
        end else if (!stop_q) begin
            counter_q <= counter_q + 64'd1;
        end
    end

    assign equal      = (counter_q == compare_q);
    assign match_edge = equal && !equal_q;          // first cycle of equality only

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            equal_q <= 1'b0;
            seq_q   <= '0;
        end else begin
            equal_q <= equal;
            if (match_edge) begin
                seq_q <= seq_q + 8'd1;              // wraps after 255
            end
        end
    end

    assign interrupt_o            = match_edge && config_q.interrupt_enable;
    assign event_valid_o          = match_edge;     // logged even with irq masked
    assign event_data_o.seq       = seq_q;
    assign event_data_o.timestamp = compare_q;      // equals counter this cycle

    always_comb begin
        read_data_o = '0;
        case (read_addr_i)
            ADDR_COMPARE_LOW:  read_data_o = compare_q[0];
            ADDR_COMPARE_HIGH: read_data_o = compare_q[1];
            ADDR_TIMER_LOW:    read_data_o = counter_q[0];
            ADDR_TIMER_HIGH:   read_data_o = counter_q[1];
            ADDR_CONFIG:       read_data_o = DATA_W'({stop_q, config_q});
            default:           read_data_o = '0;
        endcase
    end

endmodule : timer

`default_nettype wire

// File: verilog/timer_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module timer_capture_top #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic                           clk_i,
    input  logic                           rst_n_i,

    input  logic                           write_i,
    input  logic [timer_pkg::ADDR_W-1:0]   write_addr_i,
    input  logic [timer_pkg::DATA_W-1:0]   write_data_i,

    input  logic                           read_i,
    input  logic [timer_pkg::ADDR_W-1:0]   read_addr_i,
    output logic [timer_pkg::DATA_W-1:0]   read_data_o,

    output logic                           write_error_o,
    output logic                           read_error_o,

    output logic                           interrupt_o,
    output logic                           capture_irq_o
);

    import timer_pkg::*;

    localparam int SEL = ADDR_W - 1;                // block select bit

    logic              tmr_write, cap_write;
    logic              tmr_read, cap_read;
    logic [DATA_W-1:0] tmr_rdata, cap_rdata;
    logic              tmr_werr, tmr_rerr;
    logic              cap_werr, cap_rerr;
    logic              event_valid;
    capture_event_t    event_data;
    capture_event_t    fifo_head;
    logic              fifo_empty;
    logic [7:0]        fifo_count;
    logic              fifo_overflow;
    logic              fifo_pop;

    assign tmr_write = write_i && !write_addr_i[SEL];
    assign cap_write = write_i &&  write_addr_i[SEL];
    assign tmr_read  = read_i  && !read_addr_i[SEL];
    assign cap_read  = read_i  &&  read_addr_i[SEL];

    timer u_timer (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .write_i       (tmr_write),
        .write_addr_i  (write_addr_i[2:0]),
        .write_data_i  (write_data_i),
        .read_i        (tmr_read),
        .read_addr_i   (read_addr_i[2:0]),
        .read_data_o   (tmr_rdata),
        .write_error_o (tmr_werr),
        .read_error_o  (tmr_rerr),
        .interrupt_o   (interrupt_o),
        .event_valid_o (event_valid),
        .event_data_o  (event_data)
    );

    event_fifo #(
        .payload_t (capture_event_t),
        .DEPTH     (FIFO_DEPTH)
    ) u_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_i      (event_valid),                 // no ready, full drops it
        .push_data_i (event_data),
        .pop_i       (fifo_pop),
        .head_o      (fifo_head),
        .empty_o     (fifo_empty),
        .count_o     (fifo_count),
        .overflow_o  (fifo_overflow)
    );

    capture_reader #(
        .DEPTH (FIFO_DEPTH)
    ) u_capture (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .write_i       (cap_write),
        .write_addr_i  (write_addr_i[2:0]),
        .read_i        (cap_read),
        .read_addr_i   (read_addr_i[2:0]),
        .read_data_o   (cap_rdata),
        .write_error_o (cap_werr),
        .read_error_o  (cap_rerr),
        .head_i        (fifo_head),
        .empty_i       (fifo_empty),
        .count_i       (fifo_count),
        .overflow_i    (fifo_overflow),
        .pop_o         (fifo_pop),
        .capture_irq_o (capture_irq_o)
    );

    assign read_data_o   = read_addr_i[SEL] ? cap_rdata : tmr_rdata;
    assign write_error_o = tmr_werr || cap_werr;    // only the strobed block can flag
    assign read_error_o  = tmr_rerr || cap_rerr;

endmodule : timer_capture_top

`default_nettype wire

// File: verilog/timer_pkg.sv
`default_nettype none

package timer_pkg;

    localparam int DATA_W = 32;                     // bus data width
    localparam int ADDR_W = 4;                      // bus address width, msb picks the block

    // timer window, local addresses
    localparam logic [2:0] ADDR_COMPARE_LOW  = 3'd0;
    localparam logic [2:0] ADDR_COMPARE_HIGH = 3'd1;
    localparam logic [2:0] ADDR_TIMER_LOW    = 3'd2;
    localparam logic [2:0] ADDR_TIMER_HIGH   = 3'd3;
    localparam logic [2:0] ADDR_CONFIG       = 3'd4; // 5..7 flag an error

    // capture window, local addresses (8..10 on the full bus)
    localparam logic [2:0] ADDR_HEAD_LOW     = 3'd0;
    localparam logic [2:0] ADDR_HEAD_HIGH    = 3'd1; // read pops the head
    localparam logic [2:0] ADDR_STATUS       = 3'd2; // 3..7 flag an error

    typedef struct packed {
        logic interrupt_enable;                     // bit 2, irq gate
        logic one_shot;                             // bit 1, stop after first match
        logic enable;                               // bit 0, count enable
    } timer_config_t;

    typedef struct packed {
        logic [7:0]  seq;                           // running match number
        logic [63:0] timestamp;                     // compare value at match
    } capture_event_t;

    typedef struct packed {
        logic       overflow;                       // sticky, events were dropped
        logic [7:0] count;                          // entries waiting
    } capture_status_t;

endpackage : timer_pkg

`default_nettype wire
